// File: source/synth_pkg.sv
package synth_pkg;

    localparam int CLKS_PER_BIT  = 16;                    // UART oversampling
    localparam int HALF_BIT      = CLKS_PER_BIT / 2;
    localparam int BIT_CNT_W     = $clog2(CLKS_PER_BIT);
    localparam int I2S_WORD_BITS = 16;                    // Doubled 8-bit sample
    localparam int I2S_CNT_W     = $clog2(I2S_WORD_BITS);

    typedef logic [7:0]           sample_t;
    typedef logic [7:0]           phase_t;
    typedef logic [3:0]           note_t;
    typedef logic [7:0]           period_t;
    typedef logic [7:0]           rx_byte_t;
    typedef logic [BIT_CNT_W-1:0] bit_cnt_t;
    typedef logic [I2S_CNT_W-1:0] i2s_cnt_t;

    // Clocks per phase step, 40 - 2.4*n rounded down
    localparam period_t NOTE_PERIOD [16] = '{
        8'd40, 8'd37, 8'd35, 8'd32,
        8'd30, 8'd28, 8'd25, 8'd23,
        8'd20, 8'd18, 8'd16, 8'd13,
        8'd11, 8'd8,  8'd6,  8'd4
    };

    // Command bytes
    localparam rx_byte_t CMD_TRI = 8'h54;                 // 'T'
    localparam rx_byte_t CMD_SAW = 8'h53;                 // 'S'
    localparam rx_byte_t CMD_SQR = 8'h51;                 // 'Q'
    localparam rx_byte_t ASCII_0 = 8'h30;
    localparam rx_byte_t ASCII_9 = 8'h39;
    localparam rx_byte_t ASCII_A = 8'h41;
    localparam rx_byte_t ASCII_F = 8'h46;

    typedef enum logic [1:0] {
        WAVE_TRI,
        WAVE_SAW,
        WAVE_SQR
    } wave_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    typedef struct packed {
        wave_e wave;
        note_t note;
    } voice_cfg_t;

endpackage

// File: source/bit_timer.sv
`timescale 1ns/100ps

module bit_timer
    import synth_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic restart,
    output logic tick
);

    bit_cnt_t count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (restart) begin
            count <= bit_cnt_t'(HALF_BIT);                // Realign to mid-bit
        end else if (count == bit_cnt_t'(CLKS_PER_BIT - 1)) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign tick = (count == bit_cnt_t'(CLKS_PER_BIT - 1));

endmodule

// File: source/uart_rx_fsm.sv
`timescale 1ns/100ps

module uart_rx_fsm
    import synth_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     rx,
    output logic     byte_valid,
    output rx_byte_t byte_data
);

    rx_state_e state;
    logic      rx_meta;
    logic      rx_sync;
    logic      rx_prev;
    logic      restart;
    logic      tick;
    logic [2:0] bit_idx;
    rx_byte_t  shift_reg;

    // Line idles high, so the synchronizer resets to 1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign restart = (state == RX_IDLE) && rx_prev && !rx_sync;   // Start bit edge

    bit_timer u_bit_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .restart (restart),
        .tick    (tick)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= RX_IDLE;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (restart) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (tick) begin
                        state   <= rx_sync ? RX_IDLE : RX_DATA;   // Glitch rejects
                        bit_idx <= '0;
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (tick) begin
                        byte_valid <= rx_sync;            // Framing error drops byte
                        state      <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && tick) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

    assign byte_data = shift_reg;

endmodule

// File: source/command_decoder.sv
`timescale 1ns/100ps

module command_decoder
    import synth_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       byte_valid,
    input  rx_byte_t   byte_data,
    output voice_cfg_t cfg
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg <= '{wave: WAVE_TRI, note: '0};
        end else if (byte_valid) begin
            case (byte_data)
                CMD_TRI: cfg.wave <= WAVE_TRI;
                CMD_SAW: cfg.wave <= WAVE_SAW;
                CMD_SQR: cfg.wave <= WAVE_SQR;
                default: begin
                    if (byte_data >= ASCII_0 && byte_data <= ASCII_9) begin
                        cfg.note <= byte_data[3:0];               // '0'..'9' low nibble
                    end else if (byte_data >= ASCII_A && byte_data <= ASCII_F) begin
                        cfg.note <= byte_data[3:0] + 4'd9;        // 'A' is 0x41
                    end
                end
            endcase
        end
    end

endmodule

// File: source/note_divider.sv
`timescale 1ns/100ps

module note_divider
    import synth_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  note_t note,
    output logic  step
);

    period_t count;
    period_t period;
    note_t   last_note;

    assign period = NOTE_PERIOD[note];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count     <= '0;
            last_note <= '0;
            step      <= 1'b0;
        end else begin
            last_note <= note;
            step      <= 1'b0;
            if (note != last_note) begin
                count <= '0;                              // New pitch starts fresh
            end else if (count == period - 8'd1) begin
                count <= '0;
                step  <= 1'b1;
            end else begin
                count <= count + 8'd1;
            end
        end
    end

endmodule

// File: source/waveform_generator.sv
`timescale 1ns/100ps

module waveform_generator
    import synth_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    step,
    input  wave_e   wave,
    output sample_t sample
);

    phase_t phase;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (step) begin
            phase <= phase + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        case (wave)
            WAVE_SAW: sample <= phase;
            WAVE_SQR: sample <= phase[7] ? 8'hFF : 8'h00;
            WAVE_TRI: begin
                if (phase[7]) begin
                    sample <= {~phase[6:0], 1'b0};        // Falling half, stays even
                end else begin
                    sample <= {phase[6:0], 1'b0};
                end
            end
            default: sample <= phase;
        endcase
    end

endmodule

// File: source/i2s_transmitter.sv
`timescale 1ns/100ps

module i2s_transmitter
    import synth_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t sample,
    output logic    sck,
    output logic    ws,
    output logic    sd
);

    i2s_cnt_t                 bit_cnt;
    logic                     word_end;
    logic [I2S_WORD_BITS-1:0] shift_reg;

    assign word_end = (bit_cnt == i2s_cnt_t'(I2S_WORD_BITS - 1));

    // Outputs move only when sck is about to fall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck     <= 1'b0;
            ws      <= 1'b0;
            sd      <= 1'b0;
            bit_cnt <= i2s_cnt_t'(I2S_WORD_BITS - 1);    // First fall opens a word
        end else begin
            sck <= ~sck;
            if (sck) begin
                if (word_end) begin
                    bit_cnt <= '0;
                    ws      <= ~ws;
                    sd      <= sample[7];                 // MSB goes out with ws
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    sd      <= shift_reg[I2S_WORD_BITS-1];
                end
            end
        end
    end

    // Holds the rest of the word, already past its MSB
    always_ff @(posedge clk) begin
        if (sck) begin
            if (word_end) begin
                shift_reg <= {sample[6:0], sample, 1'b0};
            end else begin
                shift_reg <= {shift_reg[I2S_WORD_BITS-2:0], 1'b0};
            end
        end
    end

endmodule

// File: source/wave_synth_top.sv
`timescale 1ns/100ps

module wave_synth_top
    import synth_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    output logic i2s_sck,
    output logic i2s_ws,
    output logic i2s_sd
);

    logic       byte_valid;
    rx_byte_t   byte_data;
    voice_cfg_t cfg;
    logic       step;
    sample_t    sample;

    uart_rx_fsm u_uart_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx         (rx),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    command_decoder u_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .cfg        (cfg)
    );

    note_divider u_divider (
        .clk   (clk),
        .rst_n (rst_n),
        .note  (cfg.note),
        .step  (step)
    );

    waveform_generator u_wavegen (
        .clk    (clk),
        .rst_n  (rst_n),
        .step   (step),
        .wave   (cfg.wave),
        .sample (sample)
    );

    i2s_transmitter u_i2s (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (sample),
        .sck    (i2s_sck),
        .ws     (i2s_ws),
        .sd     (i2s_sd)
    );

endmodule

// File: tests/synth_asserts.sv
`timescale 1ns/100ps

module synth_asserts (
    input logic clk,
    input logic rst_n,
    input logic sck,
    input logic ws,
    input logic byte_valid
);

    int fail_count = 0;                                   // Read by the testbench top

    ws_on_sck_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(ws) |-> $fell(sck))
        else begin
            $error("ws changed without a falling sck edge");
            fail_count++;
        end

    byte_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        byte_valid |=> !byte_valid)
        else begin
            $error("byte_valid held high for more than one cycle");
            fail_count++;
        end

    // First cycle out of reset has no toggle history yet
    sck_toggles: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (sck != $past(sck)))
        else begin
            $error("sck missed a toggle");
            fail_count++;
        end

endmodule

// File: tests/synth_checker.sv
`timescale 1ns/100ps

module synth_checker
    import synth_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i2s_sck,
    input  logic       i2s_ws,
    input  logic       i2s_sd,
    input  voice_cfg_t model_cfg,
    input  int         cmd_seq,
    input  logic       done,
    output logic       finished,
    output int         errors
);

    localparam int WORD_CLKS = 2 * I2S_WORD_BITS;         // Clocks between sample loads

    logic    sck_q;
    logic    ws_q;
    sample_t prev_sample;
    int      seen_seq;
    int      skip;
    int      test_idx;
    int      test_words;
    int      test_errors;
    int      passed_tests;
    int      total_words;
    wave_e   test_wave;
    note_t   test_note;

    task automatic report_error(input string msg);
        $display("%s", msg);
        errors++;
        test_errors++;
    endtask

    task automatic expect_low(input string name, input logic value);
        if (value !== 1'b0) begin
            report_error($sformatf("FAILED %s during reset: got %h expected 0", name, value));
        end
    endtask

    // Pins are read at falling clk edges where they are stable
    task automatic next_sck_rise(output logic ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < 8 && !ok; n++) begin
            @(negedge clk);
            ok    = i2s_sck && !sck_q;
            sck_q = i2s_sck;
        end
    endtask

    task automatic find_word_start(output logic ok);
        int   n;
        logic edge_ok;
        logic found;
        edge_ok = 1'b1;
        found   = 1'b0;
        ws_q    = i2s_ws;
        for (n = 0; n < 4 * I2S_WORD_BITS && edge_ok && !found; n++) begin
            next_sck_rise(edge_ok);
            found = edge_ok && (i2s_ws != ws_q);
        end
        if (!edge_ok) begin
            report_error("timeout: sck stopped toggling before the first word");
        end else if (!found) begin
            report_error("timeout: ws never toggled after reset");
        end
        ok = found;
    endtask

    // Starts on the rising edge that opens a word, ends on the next one
    task automatic read_word(output logic [15:0] word, output logic ok);
        int i;
        ok   = 1'b1;
        ws_q = i2s_ws;
        word = 16'(i2s_sd);
        for (i = 1; i < I2S_WORD_BITS && ok; i++) begin
            next_sck_rise(ok);
            if (ok && i2s_ws != ws_q) begin
                report_error($sformatf("ws level ended after %0d sck rising edges", i));
            end
            word = {word[14:0], i2s_sd};
        end
        if (ok) begin
            next_sck_rise(ok);
        end
        if (!ok) begin
            report_error("timeout: sck stopped toggling inside an I2S word");
        end else if (i2s_ws == ws_q) begin
            report_error("ws held longer than 16 sck rising edges");
        end
    endtask

    task automatic close_test();
        if (test_errors == 0) begin
            passed_tests++;
        end
        $display("test %0d %s note %0d: %0d words checked, %0d errors, %s",
                 test_idx, test_wave.name(), test_note, test_words, test_errors,
                 (test_errors == 0) ? "passed" : "failed");
        test_idx++;
        test_words  = 0;
        test_errors = 0;
        test_wave   = model_cfg.wave;
        test_note   = model_cfg.note;
    endtask

    task automatic check_word(input logic [15:0] word);
        sample_t s;
        sample_t diff;
        int      lo;
        s = word[7:0];
        if (word[15:8] != word[7:0]) begin
            report_error($sformatf("FAILED i2s_sd word: upper %h lower %h", word[15:8], s));
        end
        if (cmd_seq != seen_seq) begin                    // New setting, words in flight are stale
            close_test();
            seen_seq = cmd_seq;
            skip     = 2;
        end
        if (total_words == 0 && word != 16'h0000) begin
            report_error($sformatf("FAILED i2s_sd first word: got %h expected 0000", word));
        end
        if (skip > 0) begin
            skip--;
        end else begin
            test_words++;
            case (model_cfg.wave)
                WAVE_SQR: begin
                    if (s != 8'h00 && s != 8'hFF) begin
                        report_error($sformatf("FAILED i2s_sd square: got %h expected 00 or ff", s));
                    end
                end
                WAVE_SAW: begin
                    lo   = WORD_CLKS / int'(NOTE_PERIOD[model_cfg.note]);
                    diff = s - prev_sample;
                    if (int'(diff) != lo && int'(diff) != lo + 1) begin
                        report_error($sformatf("FAILED i2s_sd saw step: got %h expected %h or %h",
                                               diff, lo, lo + 1));
                    end
                end
                default: begin
                    if (s[0]) begin
                        report_error($sformatf("FAILED i2s_sd triangle: got %h expected even", s));
                    end
                end
            endcase
        end
        prev_sample = s;
        total_words++;
    endtask

    initial begin
        logic        ok;
        logic [15:0] word;
        int          n;
        errors       = 0;
        finished     = 1'b0;
        seen_seq     = 0;
        skip         = 0;
        test_idx     = 0;
        test_words   = 0;
        test_errors  = 0;
        passed_tests = 0;
        total_words  = 0;
        prev_sample  = '0;
        test_wave    = WAVE_TRI;
        test_note    = '0;
        ok           = 1'b0;
        for (n = 0; n < 100 && !ok; n++) begin
            @(negedge clk);
            if (!rst_n) begin
                expect_low("i2s_sck", i2s_sck);
                expect_low("i2s_ws", i2s_ws);
                expect_low("i2s_sd", i2s_sd);
            end else begin
                ok = 1'b1;
            end
        end
        sck_q = i2s_sck;
        if (!ok) begin
            report_error("reset was never released");
        end else begin
            find_word_start(ok);
        end
        while (!done) begin
            if (ok) begin
                read_word(word, ok);
                if (ok) begin
                    check_word(word);
                end
            end else begin
                @(negedge clk);                           // Sync lost, idle until the end
            end
        end
        close_test();
        if (total_words == 0) begin
            report_error("no I2S words were decoded");
        end
        $display("tests: %0d passed, %0d failed; words: %0d; errors: %0d",
                 passed_tests, test_idx - passed_tests, total_words, errors);
        finished = 1'b1;
    end

endmodule

// File: tests/wave_synth_tb.sv
`timescale 1ns/100ps

module wave_synth_tb
    import synth_pkg::*;
();

    localparam int NUM_FRAMES = 40;
    localparam int HOLD_CLKS  = 200;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       rx;
    logic       i2s_sck;
    logic       i2s_ws;
    logic       i2s_sd;
    logic       done;
    logic       finished;
    int         errors;
    int         cmd_seq;
    int         seed;
    voice_cfg_t model_cfg;

    always #5 clk = ~clk;

    wave_synth_top DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx      (rx),
        .i2s_sck (i2s_sck),
        .i2s_ws  (i2s_ws),
        .i2s_sd  (i2s_sd)
    );

    synth_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .i2s_sck   (i2s_sck),
        .i2s_ws    (i2s_ws),
        .i2s_sd    (i2s_sd),
        .model_cfg (model_cfg),
        .cmd_seq   (cmd_seq),
        .done      (done),
        .finished  (finished),
        .errors    (errors)
    );

    bind wave_synth_top synth_asserts u_asserts (
        .clk        (clk),
        .rst_n      (rst_n),
        .sck        (i2s_sck),
        .ws         (i2s_ws),
        .byte_valid (byte_valid)
    );

    // Decoder rule: wave letters, note digits and hex letters, rest ignored
    function automatic voice_cfg_t apply_byte(input voice_cfg_t cfg, input rx_byte_t b);
        voice_cfg_t upd;
        upd = cfg;
        if (b == "T") upd.wave = WAVE_TRI;
        else if (b == "S") upd.wave = WAVE_SAW;
        else if (b == "Q") upd.wave = WAVE_SQR;
        else if (b >= "0" && b <= "9") upd.note = note_t'(b - "0");
        else if (b >= "A" && b <= "F") upd.note = note_t'(b - "A" + 8'd10);
        return upd;
    endfunction

    function automatic logic is_command(input rx_byte_t b);
        return b == "T" || b == "S" || b == "Q" ||
               (b >= "0" && b <= "9") || (b >= "A" && b <= "F");
    endfunction

    task automatic pick_byte(output rx_byte_t b);
        int kind;
        int idx;
        kind = $unsigned($random(seed)) % 3;
        idx  = $unsigned($random(seed)) % 16;
        if (kind == 0) begin
            b = (idx % 3 == 0) ? CMD_TRI : (idx % 3 == 1) ? CMD_SAW : CMD_SQR;
        end else if (kind == 1) begin
            b = (idx < 10) ? rx_byte_t'("0" + idx) : rx_byte_t'("A" + idx - 10);
        end else begin
            b = rx_byte_t'($random(seed));
            if (is_command(b)) begin
                b = b ^ 8'h80;                            // All commands sit below 0x80
            end
        end
    endtask

    task automatic drive_bit(input logic value);
        rx = value;
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic send_frame(input rx_byte_t b);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            drive_bit(b[i]);                              // LSB first
        end
        drive_bit(1'b1);
        @(posedge clk);                                   // Model moves off the checker's edge
        model_cfg = apply_byte(model_cfg, b);
        cmd_seq   = cmd_seq + 1;
        @(negedge clk);
        repeat (HOLD_CLKS + $unsigned($random(seed)) % 64) @(negedge clk);
    endtask

    initial begin
        rx_byte_t b;
        int       n;
        seed      = 32'h3ec2_cb5f;
        rst_n     = 1'b0;
        rx        = 1'b1;
        done      = 1'b0;
        cmd_seq   = 0;
        model_cfg = '{wave: WAVE_TRI, note: '0};
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (HOLD_CLKS) @(negedge clk);
        for (n = 0; n < NUM_FRAMES; n++) begin
            pick_byte(b);
            send_frame(b);
        end
        @(posedge clk);                                   // End flag also off the checker's edge
        done = 1'b1;
        for (n = 0; n < 200 && !finished; n++) begin
            @(negedge clk);
        end
        if (!finished) begin
            $display("checker did not finish its report in time");
        end
        if (DUT.u_asserts.fail_count != 0) begin
            $display("%0d assertion failures", DUT.u_asserts.fail_count);
        end
        if (finished && errors == 0 && DUT.u_asserts.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: wave_synth.f
source/synth_pkg.sv
source/bit_timer.sv
source/uart_rx_fsm.sv
source/command_decoder.sv
source/note_divider.sv
source/waveform_generator.sv
source/i2s_transmitter.sv
source/wave_synth_top.sv
tests/synth_asserts.sv
tests/synth_checker.sv
tests/wave_synth_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the wave_synth testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module wave_synth_tb -f wave_synth.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vwave_synth_tb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
